// File: sources.f
rtl/audio_tx_pkg.sv
rtl/audio_frame_if.sv
rtl/sample_latch.sv
rtl/bit_clock_timer.sv
rtl/tx_sequencer.sv
rtl/serial_formatter.sv
rtl/i2s_lj_tx_top.sv
tb/tb_i2s_lj_tx.sv

// File: Makefile
TOP := tb_i2s_lj_tx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: tb/tb_i2s_lj_tx.sv
////////////////////////////////////////////////////////////////////////////
//
// Testbench for the left-justified I2S transmitter
//  - Clock, reset and LFSR sample stimulus
//  - Reference sample latch and ASDATA deserializer
//  - Idle, clock shape, payload, coherence and reset checks
//
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_i2s_lj_tx;

  localparam int SAMPLE_W      = 24;
  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYC     = 16;
  localparam int SECTION_CYC   = 256;
  localparam int FRAME_CYC     = 2 * SECTION_CYC;
  localparam int RANDOM_FRAMES = 24;
  // Random frames plus directed tests, rounded up
  localparam int TEST_FRAMES   = RANDOM_FRAMES + 16;
  localparam int TIMEOUT_CYC   = RESET_CYC + TEST_FRAMES * FRAME_CYC + 1000;
  // Posedges from strobe release until the LRCLK rise is seen
  localparam int START_WINDOW  = 4;

  logic                AMCLK_i;
  logic                nARST;
  logic [SAMPLE_W-1:0] APDATA_LEFT_i;
  logic [SAMPLE_W-1:0] APDATA_RIGHT_i;
  logic [1:0]          APDATA_VALID_i;
  logic                ASCLK_o;
  logic                ASDATA_o;
  logic                ALRCLK_o;

  // Stimulus state
  logic [15:0]         lfsr_state = 16'd50;
  logic [SAMPLE_W-1:0] wr_left = '0;
  logic [SAMPLE_W-1:0] wr_right = '0;
  logic                idle_expect;
  int                  cycles = 0;

  // Reference latch, value after the coming edge and after the last one
  logic [SAMPLE_W-1:0] next_l = '0;
  logic [SAMPLE_W-1:0] next_r = '0;
  logic [SAMPLE_W-1:0] now_l = '0;
  logic [SAMPLE_W-1:0] now_r = '0;
  // Latch history, words reload from the value two edges back
  logic [SAMPLE_W-1:0] hist1_l = '0;
  logic [SAMPLE_W-1:0] hist1_r = '0;
  logic [SAMPLE_W-1:0] hist2_l = '0;
  logic [SAMPLE_W-1:0] hist2_r = '0;

  // Deserializer
  logic                prev_asclk = 1'b1;
  logic                prev_alrclk = 1'b0;
  logic                streaming = 1'b0;
  logic [31:0]         rx_bits = '0;
  logic [31:0]         rx_left = '0;
  logic [31:0]         rx_right = '0;
  logic [31:0]         exp_left = '0;
  logic [31:0]         exp_right = '0;
  int                  rx_count = 0;
  int                  half_cnt = 0;
  int                  sect_cnt = 0;
  int                  frames_started = 0;
  int                  slots_checked = 0;

  i2s_lj_tx_top #(
    .SAMPLE_W(SAMPLE_W)
  ) uut (
    .AMCLK_i        (AMCLK_i),
    .nARST          (nARST),
    .APDATA_LEFT_i  (APDATA_LEFT_i),
    .APDATA_RIGHT_i (APDATA_RIGHT_i),
    .APDATA_VALID_i (APDATA_VALID_i),
    .ASCLK_o        (ASCLK_o),
    .ASDATA_o       (ASDATA_o),
    .ALRCLK_o       (ALRCLK_o)
  );

  initial begin
    AMCLK_i = 1'b0;
    forever #(CLK_PERIOD / 2) AMCLK_i = ~AMCLK_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic string mismatch_text(input string name, input logic [31:0] got,
                                          input logic [31:0] exp);
    return $sformatf("mismatch %s got=%h exp=%h", name, got, exp);
  endfunction

  // Slot on the wire, sample MSB first then copies of its LSB
  function automatic logic [31:0] expected_slot(input logic [SAMPLE_W-1:0] smp);
    return {smp, {(32 - SAMPLE_W){smp[0]}}};
  endfunction

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge AMCLK_i);
  endtask

  // Returns on the posedge after the next LRCLK rise
  task automatic wait_frame_start();
    int n;
    n = frames_started;
    while (frames_started == n)
      @(posedge AMCLK_i);
  endtask

  // Strobe fresh random samples on the selected channels for one cycle
  task automatic drive_samples(input logic [1:0] which);
    logic [31:0] r;
    @(posedge AMCLK_i);
    if (which[1]) begin
      r = take_bits(SAMPLE_W);
      wr_left = r[SAMPLE_W-1:0];
      APDATA_LEFT_i <= wr_left;
    end
    if (which[0]) begin
      r = take_bits(SAMPLE_W);
      wr_right = r[SAMPLE_W-1:0];
      APDATA_RIGHT_i <= wr_right;
    end
    APDATA_VALID_i <= which;
    @(posedge AMCLK_i);
    APDATA_VALID_i <= 2'b00;
  endtask

  // Second strobe was in the cycle just released
  task automatic expect_start();
    int n;
    n = frames_started;
    for (int i = 0; i < START_WINDOW && frames_started == n; i++)
      @(posedge AMCLK_i);
    assert (frames_started != n)
      else stop_on_error("ALRCLK_o did not rise after both channels were strobed");
  endtask

  // Writes at random points of each frame, random channel mix
  task automatic stream_random_frames(input int count);
    logic [31:0] r;
    int          gap;
    for (int f = 0; f < count; f++) begin
      wait_frame_start();
      gap = int'(take_bits(8)) + int'(take_bits(7));
      wait_cycles(gap);
      r = take_bits(2);
      drive_samples(r[1:0]);
    end
  endtask

  // New pair written in the left section shows up only one frame later
  task automatic check_frame_coherence();
    logic [SAMPLE_W-1:0] old_l;
    logic [SAMPLE_W-1:0] old_r;
    wait_frame_start();
    old_l = wr_left;
    old_r = wr_right;
    wait_cycles(50);
    drive_samples(2'b11);
    wait_frame_start();
    assert (rx_left == expected_slot(old_l))
      else stop_on_error(mismatch_text("ASDATA_o left slot", rx_left, expected_slot(old_l)));
    assert (rx_right == expected_slot(old_r))
      else stop_on_error(mismatch_text("ASDATA_o right slot", rx_right, expected_slot(old_r)));
    wait_frame_start();
    assert (rx_left == expected_slot(wr_left))
      else stop_on_error(mismatch_text("ASDATA_o left slot", rx_left, expected_slot(wr_left)));
    assert (rx_right == expected_slot(wr_right))
      else stop_on_error(mismatch_text("ASDATA_o right slot", rx_right,
                                       expected_slot(wr_right)));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  // Idle levels whenever the link must be silent
  assert property (@(negedge AMCLK_i) idle_expect |-> (ASCLK_o && !ASDATA_o && !ALRCLK_o))
    else stop_on_error(mismatch_text("ASCLK_o,ASDATA_o,ALRCLK_o",
                                     {29'd0, ASCLK_o, ASDATA_o, ALRCLK_o}, 32'h4));

  // Reference model and deserializer, sampled at the falling edge
  initial begin
    forever begin
      @(negedge AMCLK_i);
      now_l = next_l;
      now_r = next_r;
      if (!nARST) begin
        next_l = '0;
        next_r = '0;
        streaming = 1'b0;
      end else begin
        if (APDATA_VALID_i[1])
          next_l = APDATA_LEFT_i;
        if (APDATA_VALID_i[0])
          next_r = APDATA_RIGHT_i;
        if (streaming) begin
          half_cnt++;
          sect_cnt++;
          if (ASCLK_o != prev_asclk) begin
            assert (half_cnt == 4)
              else stop_on_error(mismatch_text("ASCLK_o half period", half_cnt, 4));
            half_cnt = 0;
            // Receiver takes the bit on ASCLK rising
            if (ASCLK_o) begin
              rx_bits = {rx_bits[30:0], ASDATA_o};
              rx_count++;
            end
          end
          assert (half_cnt < 4 && sect_cnt <= SECTION_CYC)
            else stop_on_error("output clocks stopped toggling while streaming");
        end
        if (ALRCLK_o != prev_alrclk) begin
          assert (prev_asclk && !ASCLK_o)
            else stop_on_error("ALRCLK_o changed away from an ASCLK_o falling edge");
          if (streaming) begin
            assert (sect_cnt == SECTION_CYC)
              else stop_on_error(mismatch_text("ALRCLK_o level length", sect_cnt, SECTION_CYC));
            assert (rx_count == 32)
              else stop_on_error(mismatch_text("ASCLK_o rises per slot", rx_count, 32));
            if (ALRCLK_o) begin
              assert (rx_bits == exp_right)
                else stop_on_error(mismatch_text("ASDATA_o right slot", rx_bits, exp_right));
              rx_right = rx_bits;
            end else begin
              assert (rx_bits == exp_left)
                else stop_on_error(mismatch_text("ASDATA_o left slot", rx_bits, exp_left));
              rx_left = rx_bits;
            end
            slots_checked++;
          end
          // Right to left boundary, both words came from one reload
          if (ALRCLK_o) begin
            exp_left = expected_slot(hist2_l);
            exp_right = expected_slot(hist2_r);
            frames_started++;
          end
          streaming = 1'b1;
          sect_cnt = 0;
          half_cnt = 0;
          rx_count = 0;
          rx_bits = '0;
        end
      end
      hist2_l = hist1_l;
      hist2_r = hist1_r;
      hist1_l = now_l;
      hist1_r = now_r;
      prev_asclk = ASCLK_o;
      prev_alrclk = ALRCLK_o;
    end
  end

  // Run limit
  initial begin
    while (cycles < TIMEOUT_CYC) begin
      @(posedge AMCLK_i);
      cycles++;
    end
    $display("timeout after %0d cycles, the stream never finished", cycles);
    $display("Something failed");
    $fatal(1, "run limit reached");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    nARST = 1'b0;
    APDATA_LEFT_i = '0;
    APDATA_RIGHT_i = '0;
    APDATA_VALID_i = 2'b00;
    idle_expect = 1'b0;
    repeat (RESET_CYC) @(posedge AMCLK_i);
    nARST <= 1'b1;
    idle_expect <= 1'b1;

    // Left only, link stays silent
    wait_cycles(8);
    drive_samples(2'b10);
    wait_cycles(40);
    idle_expect <= 1'b0;
    drive_samples(2'b01);
    expect_start();

    stream_random_frames(RANDOM_FRAMES);
    check_frame_coherence();

    // Reset in the middle of a left section
    wait_frame_start();
    wait_cycles(100);
    nARST <= 1'b0;
    @(posedge AMCLK_i);
    idle_expect <= 1'b1;
    wait_cycles(RESET_CYC - 1);
    nARST <= 1'b1;
    wait_cycles(40);
    drive_samples(2'b01);
    wait_cycles(40);
    idle_expect <= 1'b0;
    drive_samples(2'b10);
    expect_start();

    stream_random_frames(4);
    wait_frame_start();
    if (slots_checked >= 2 * RANDOM_FRAMES) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_on_error("too few slots reached the payload check");
    end
  end

endmodule

`default_nettype wire

// File: rtl/i2s_lj_tx_top.sv
////////////////////////////////////////////////////////////////////////////
//
// Left-justified I2S transmitter top level
//  - Sample latch, bit clock timer, sequencer and serial formatter
//  - 24.576 MHz master clock, 48 kHz frames of 2 x 32 bit slots
//
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module i2s_lj_tx_top #(
  parameter int SAMPLE_W = 24
) (
  input  logic                AMCLK_i,
  input  logic                nARST,
  // Parallel samples, valid bit 1 left, bit 0 right
  input  logic [SAMPLE_W-1:0] APDATA_LEFT_i,
  input  logic [SAMPLE_W-1:0] APDATA_RIGHT_i,
  input  logic [1:0]          APDATA_VALID_i,
  // Serial audio to the HDMI transmitter
  output logic                ASCLK_o,
  output logic                ASDATA_o,
  output logic                ALRCLK_o
);

  logic [SAMPLE_W-1:0] left_hold;
  logic [SAMPLE_W-1:0] right_hold;
  logic                both_seen;

  // Shared ticks and control
  audio_frame_if frame_if ();

  sample_latch #(
    .SAMPLE_W(SAMPLE_W)
  ) u_sample_latch (
    .AMCLK_i        (AMCLK_i),
    .nARST          (nARST),
    .apdata_left_i  (APDATA_LEFT_i),
    .apdata_right_i (APDATA_RIGHT_i),
    .apdata_valid_i (APDATA_VALID_i),
    .left_o         (left_hold),
    .right_o        (right_hold),
    .both_seen_o    (both_seen)
  );

  bit_clock_timer u_bit_clock_timer (
    .AMCLK_i  (AMCLK_i),
    .nARST    (nARST),
    .frame_if (frame_if)
  );

  tx_sequencer u_tx_sequencer (
    .AMCLK_i     (AMCLK_i),
    .nARST       (nARST),
    .both_seen_i (both_seen),
    .frame_if    (frame_if)
  );

  serial_formatter #(
    .SAMPLE_W(SAMPLE_W)
  ) u_serial_formatter (
    .AMCLK_i  (AMCLK_i),
    .nARST    (nARST),
    .left_i   (left_hold),
    .right_i  (right_hold),
    .frame_if (frame_if),
    .asclk_o  (ASCLK_o),
    .asdata_o (ASDATA_o),
    .alrclk_o (ALRCLK_o)
  );

endmodule

`default_nettype wire

// File: rtl/serial_formatter.sv
////////////////////////////////////////////////////////////////////////////
//
// Left-justified serial output stage
//  - Pads each sample to a full slot by repeating its LSB
//  - Shifts the selected channel word out MSB first
//  - Generates ASCLK and LRCLK from the timer ticks, idle outside RUN
//
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module serial_formatter #(
  parameter int SAMPLE_W = 24
) (
  input  logic                AMCLK_i,
  input  logic                nARST,
  input  logic [SAMPLE_W-1:0] left_i,
  input  logic [SAMPLE_W-1:0] right_i,
  audio_frame_if.fmt          frame_if,
  output logic                asclk_o,
  output logic                asdata_o,
  output logic                alrclk_o
);

  import audio_tx_pkg::*;

  localparam int IDX_W = $clog2(WORD_W);

  // Sample left-aligned in the slot, LSB copies below it
  function automatic logic [WORD_W-1:0] pad_word(input logic [SAMPLE_W-1:0] smp);
    logic [WORD_W-1:0] w;
    w = {WORD_W{smp[0]}};
    w[WORD_W-1 -: SAMPLE_W] = smp;
    return w;
  endfunction

  logic [WORD_W-1:0] word_left;
  logic [WORD_W-1:0] word_right;
  logic              sel_left;
  logic [IDX_W-1:0]  bit_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Word registers

  // Both channels reloaded together, at start and after each right section
  always_ff @(posedge AMCLK_i) begin
    if (frame_if.load ||
        (frame_if.run && frame_if.section_end && frame_if.frame_reload)) begin
      word_left  <= pad_word(left_i);
      word_right <= pad_word(right_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Serializer and clock outputs

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      sel_left <= 1'b0;
      bit_idx  <= IDX_W'(WORD_W - 1);
      asclk_o  <= 1'b1;
      asdata_o <= 1'b0;
      alrclk_o <= 1'b0;
    end else if (!frame_if.run) begin
      // Idle levels, LOAD also arms the first left slot
      if (frame_if.load) begin
        sel_left <= 1'b1;
        bit_idx  <= IDX_W'(WORD_W - 1);
      end
      asclk_o  <= 1'b1;
      asdata_o <= 1'b0;
      alrclk_o <= 1'b0;
    end else begin
      if (frame_if.half_tick)
        asclk_o <= ~asclk_o;
      // Data changes with ASCLK falling
      if (frame_if.bit_tick) begin
        asdata_o <= sel_left ? word_left[bit_idx] : word_right[bit_idx];
        bit_idx  <= bit_idx - 1'b1;
      end
      if (frame_if.section_start)
        alrclk_o <= ~alrclk_o;
      // Next section sends the other channel from its MSB
      if (frame_if.section_end) begin
        sel_left <= ~sel_left;
        bit_idx  <= IDX_W'(WORD_W - 1);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/tx_sequencer.sv
////////////////////////////////////////////////////////////////////////////
//
// Transmit sequencer
//  - Keeps the link idle until both channels have data
//  - One LOAD cycle for an aligned start, then RUN until reset
//  - Tracks left/right sections to time the frame reload
//
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tx_sequencer (
  input logic         AMCLK_i,
  input logic         nARST,
  input logic         both_seen_i,
  audio_frame_if.seq  frame_if
);

  import audio_tx_pkg::*;

  seq_state_t state;

  // Set while a right section is being sent
  logic right_sect;

  ////////////////////////////////////////////////////////////////////////////
  // State machine

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          // Wait for a sample on both channels
          if (both_seen_i)
            state <= LOAD;
        end
        LOAD: begin
          state <= RUN;
        end
        RUN: begin
          // Streams until the next reset
          state <= RUN;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign frame_if.load = (state == LOAD);
  assign frame_if.run  = (state == RUN);

  ////////////////////////////////////////////////////////////////////////////
  // Channel tracking

  // First section after LOAD is left
  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      right_sect <= 1'b0;
    end else if (frame_if.load) begin
      right_sect <= 1'b0;
    end else if (frame_if.run && frame_if.section_end) begin
      right_sect <= ~right_sect;
    end
  end

  // Reload only when a right section ends, so a frame never mixes loads
  assign frame_if.frame_reload = frame_if.run & right_sect;

endmodule

`default_nettype wire

// File: rtl/bit_clock_timer.sv
////////////////////////////////////////////////////////////////////////////
//
// Section counter in master clocks
//  - Counts while running, cleared by the load pulse
//  - Decodes ASCLK half period, bit and section edge ticks
//
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module bit_clock_timer (
  input logic           AMCLK_i,
  input logic           nARST,
  audio_frame_if.timer  frame_if
);

  import audio_tx_pkg::*;

  // Counter bits below one serial bit
  localparam int BIT_LSBS = $clog2(MCLK_PER_BIT);

  logic [CNT_W-1:0] cnt;

  // Zero in the first RUN cycle, wraps 255 -> 0 once per section
  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      cnt <= '0;
    end else if (frame_if.load || !frame_if.run) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // ASCLK toggles every half bit, i.e. every 4 master clocks
  assign frame_if.half_tick = ~|cnt[BIT_LSBS-2:0];

  // New data bit every 8 master clocks, on the ASCLK falling edge
  assign frame_if.bit_tick = ~|cnt[BIT_LSBS-1:0];

  // Section boundaries, LRCLK flips at start
  assign frame_if.section_start = ~|cnt;
  assign frame_if.section_end   = (cnt == CNT_W'(SECTION_MCLKS - 1));

endmodule

`default_nettype wire

// File: rtl/sample_latch.sv
////////////////////////////////////////////////////////////////////////////
//
// Parallel sample input stage
//  - Holds the latest left and right sample on their strobes
//  - Sticky per-channel seen flags, both_seen once each channel arrived
//
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module sample_latch #(
  parameter int SAMPLE_W = 24
) (
  input  logic                AMCLK_i,
  input  logic                nARST,
  input  logic [SAMPLE_W-1:0] apdata_left_i,
  input  logic [SAMPLE_W-1:0] apdata_right_i,
  // Bit 1 strobes left, bit 0 strobes right
  input  logic [1:0]          apdata_valid_i,
  output logic [SAMPLE_W-1:0] left_o,
  output logic [SAMPLE_W-1:0] right_o,
  output logic                both_seen_o
);

  logic seen_left;
  logic seen_right;

  // Sample hold registers, cleared to silence on reset
  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      left_o  <= '0;
      right_o <= '0;
    end else begin
      if (apdata_valid_i[1])
        left_o <= apdata_left_i;
      if (apdata_valid_i[0])
        right_o <= apdata_right_i;
    end
  end

  // Seen flags stay set until the next reset
  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      seen_left  <= 1'b0;
      seen_right <= 1'b0;
    end else begin
      seen_left  <= seen_left  | apdata_valid_i[1];
      seen_right <= seen_right | apdata_valid_i[0];
    end
  end

  // High from the cycle after the second channel first arrives
  assign both_seen_o = seen_left & seen_right;

endmodule

`default_nettype wire

// File: rtl/audio_frame_if.sv
////////////////////////////////////////////////////////////////////////////
//
// Frame timing bundle between sequencer, bit clock timer and formatter
//  - Edge ticks decoded from the section counter
//  - Run level, load pulse and frame reload request
//
////////////////////////////////////////////////////////////////////////////

`default_nettype none

interface audio_frame_if;

  // Ticks from the timer, valid only while run is high
  logic half_tick;
  logic bit_tick;
  logic section_start;
  logic section_end;

  // Control from the sequencer
  logic run;
  logic load;
  logic frame_reload;

  modport timer (
    output half_tick, bit_tick, section_start, section_end,
    input  run, load
  );

  modport seq (
    input  section_end,
    output run, load, frame_reload
  );

  modport fmt (
    input half_tick, bit_tick, section_start, section_end,
    input run, load, frame_reload
  );

endinterface

`default_nettype wire

// File: rtl/audio_tx_pkg.sv
////////////////////////////////////////////////////////////////////////////
//
// Shared definitions for the left-justified I2S transmitter
//  - Frame geometry in master clocks and serial bits
//  - Sequencer state encoding
//
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package audio_tx_pkg;

  // Slot width per channel, MSB first on the wire
  localparam int WORD_W = 32;

  // Master clocks per serial bit
  // ASCLK half period is half of this
  localparam int MCLK_PER_BIT = 8;

  // One channel section, LRCLK level length
  localparam int SECTION_MCLKS = WORD_W * MCLK_PER_BIT;

  // Section counter width, wraps once per section
  localparam int CNT_W = 8;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    LOAD = 2'd1,
    RUN  = 2'd2
  } seq_state_t;

endpackage

`default_nettype wire
